/* include/agc_defines.svh */
`ifndef AGC_DEFINES_SVH
`define AGC_DEFINES_SVH

// --------------------------------------------------
// sample format
// --------------------------------------------------
`define AGC_DIN_WIDTH      8     // lane sample width.
`define AGC_DIN_POINT      7     // fraction bits of a sample.
`define AGC_PARALLEL       4     // lanes per block.
`define AGC_POW_WIDTH      16    // squared sample width with 2*din_point fraction bits.

// window and update period
`define AGC_WINDOW_LOG2    3     // moving window of 8 blocks.
`define AGC_UPDATE_BLOCKS  16    // accepted blocks between gain updates.

// --------------------------------------------------
// gain loop
// --------------------------------------------------
`define AGC_COEF_WIDTH     16    // unsigned error coefficient.
`define AGC_COEF_POINT     8
`define AGC_GAIN_WIDTH     16    // signed gain.
`define AGC_GAIN_POINT     8
`define AGC_GAIN_INIT      (1 << `AGC_GAIN_POINT)
`define AGC_GAIN_HIGH      2048  // exclusive upper limit of 8.0.
`define AGC_GAIN_LOW       0     // exclusive lower limit.
`define AGC_PROD_WIDTH     (`AGC_DIN_WIDTH + `AGC_GAIN_WIDTH)

// output queues
`define AGC_OUT_DEPTH      8
`define AGC_RPT_DEPTH      4

`endif

/* src/agc_pkg.sv */
`include "agc_defines.svh"

package agc_pkg;

    // --------------------------------------------------
    // scalar formats
    // --------------------------------------------------
    typedef logic signed [`AGC_DIN_WIDTH-1:0]  sample_t;   // q1.7 lane sample.
    typedef logic signed [`AGC_PROD_WIDTH-1:0] product_t;  // sample times gain.
    typedef logic signed [`AGC_GAIN_WIDTH-1:0] gain_t;     // q8.8 gain.
    typedef logic [`AGC_POW_WIDTH-1:0]         power_t;    // unsigned mean power.

    // --------------------------------------------------
    // blocks and reports
    // --------------------------------------------------
    // one accepted input block.
    typedef struct packed {
        sample_t [`AGC_PARALLEL-1:0] lane;
    } sample_block_t;

    // scaled lanes tagged with the gain they were multiplied by.
    typedef struct packed {
        product_t [`AGC_PARALLEL-1:0] lane;
        gain_t                        gain;
    } scaled_block_t;

    // result of one gain update.
    typedef struct packed {
        gain_t  gain;  // gain after the update.
        power_t pow;   // mean power that drove it.
        logic   held;  // candidate left the band so the gain was kept.
    } gain_report_t;

endpackage

/* src/avg_power.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module avg_power (
    input  logic                      clk,
    input  logic                      rst,
    input  agc_pkg::sample_block_t    din,
    input  logic                      din_valid,
    output logic [`AGC_POW_WIDTH-1:0] pow,
    output logic                      pow_valid
);

    localparam int par_log2   = $clog2(`AGC_PARALLEL);
    localparam int window     = 1 << `AGC_WINDOW_LOG2;
    localparam int blk_width  = `AGC_POW_WIDTH + par_log2;
    localparam int mean_shift = par_log2 + `AGC_WINDOW_LOG2;
    localparam int sum_width  = `AGC_POW_WIDTH + mean_shift;

    logic [`AGC_POW_WIDTH-1:0] sq [`AGC_PARALLEL];
    logic                      sq_valid;
    logic [blk_width-1:0]      blk_sum;
    logic [blk_width-1:0]      hist [window];
    logic [sum_width-1:0]      run_sum;

    // --------------------------------------------------
    // stage 1 squares every lane
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sq_valid <= 1'b0;
        end else begin
            sq_valid <= din_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            for (int i = 0; i < `AGC_PARALLEL; i++) begin
                sq[i] <= din.lane[i] * din.lane[i];  // never negative.
            end
        end
    end

    // --------------------------------------------------
    // stage 2 sums the lanes and moves the window
    // --------------------------------------------------
    always_comb begin
        blk_sum = '0;
        for (int i = 0; i < `AGC_PARALLEL; i++) begin
            blk_sum = blk_sum + blk_width'(sq[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pow_valid <= 1'b0;
            run_sum   <= '0;
            for (int k = 0; k < window; k++) begin
                hist[k] <= '0;  // empty slots count as zero.
            end
        end else begin
            pow_valid <= sq_valid;
            if (sq_valid) begin
                hist[0] <= blk_sum;
                for (int k = 1; k < window; k++) begin
                    hist[k] <= hist[k-1];
                end
                // oldest block leaves as the new one enters.
                run_sum <= run_sum + sum_width'(blk_sum) - sum_width'(hist[window-1]);
            end
        end
    end

    // divide by lanes times window with truncation.
    assign pow = run_sum[mean_shift +: `AGC_POW_WIDTH];

endmodule

/* src/gain_update.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module gain_update (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [`AGC_POW_WIDTH-1:0]         pow,
    input  logic                              pow_valid,
    input  logic [`AGC_POW_WIDTH-1:0]         ref_pow,
    input  logic [`AGC_COEF_WIDTH-1:0]        error_coef,
    output logic signed [`AGC_GAIN_WIDTH-1:0] gain,
    output agc_pkg::gain_report_t             rpt,
    output logic                              rpt_valid
);

    localparam int gw         = `AGC_GAIN_WIDTH;
    localparam int cnt_width  = $clog2(`AGC_UPDATE_BLOCKS);
    localparam int diff_width = `AGC_POW_WIDTH + 1;
    localparam int prod_width = diff_width + `AGC_COEF_WIDTH + 1;
    localparam int step_shift = 2 * `AGC_DIN_POINT + `AGC_COEF_POINT - `AGC_GAIN_POINT;

    localparam logic [cnt_width-1:0] cnt_last  = cnt_width'(`AGC_UPDATE_BLOCKS - 1);
    localparam logic signed [gw:0]   gain_lo   = `AGC_GAIN_LOW;
    localparam logic signed [gw:0]   gain_hi   = `AGC_GAIN_HIGH;
    localparam logic signed [gw-1:0] gain_init = `AGC_GAIN_INIT;

    logic [cnt_width-1:0]          blk_cnt;
    logic                          upd;
    logic signed [diff_width-1:0]  diff;
    logic signed [prod_width-1:0]  prod;
    logic signed [prod_width-1:0]  prod_shr;
    logic signed [gw-1:0]          step_sat;
    logic signed [gw-1:0]          step;
    logic signed [gw:0]            cand;
    logic                          in_band;
    logic [`AGC_POW_WIDTH-1:0]     pow_s1;
    logic [`AGC_POW_WIDTH-1:0]     pow_s2;
    logic [`AGC_POW_WIDTH-1:0]     pow_s3;
    logic                          diff_valid;
    logic                          prod_valid;
    logic                          step_valid;
    logic signed [gw-1:0]          gain_reg;

    assign upd = pow_valid && (blk_cnt == cnt_last);  // every update_blocks-th result.

    // --------------------------------------------------
    // cast of the scaled error to gain format
    // --------------------------------------------------
    always_comb begin
        prod_shr = prod >>> step_shift;
        if (&prod_shr[prod_width-1:gw-1] || ~|prod_shr[prod_width-1:gw-1]) begin
            step_sat = prod_shr[gw-1:0];
        end else if (prod_shr[prod_width-1]) begin
            step_sat = {1'b1, {(gw-1){1'b0}}};  // most negative step.
        end else begin
            step_sat = {1'b0, {(gw-1){1'b1}}};  // most positive step.
        end
    end

    // candidate gain is kept only strictly inside the band.
    assign cand    = {gain_reg[gw-1], gain_reg} + {step[gw-1], step};
    assign in_band = (cand > gain_lo) && (cand < gain_hi);

    // --------------------------------------------------
    // block counter, stage valids and gain register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_cnt    <= '0;
            diff_valid <= 1'b0;
            prod_valid <= 1'b0;
            step_valid <= 1'b0;
            rpt_valid  <= 1'b0;
            gain_reg   <= gain_init;  // unity.
        end else begin
            if (pow_valid) begin
                blk_cnt <= upd ? '0 : blk_cnt + 1'b1;
            end
            diff_valid <= upd;
            prod_valid <= diff_valid;
            step_valid <= prod_valid;
            rpt_valid  <= step_valid;
            if (rpt_valid) begin
                gain_reg <= rpt.gain;  // one cycle behind the report.
            end
        end
    end

    // --------------------------------------------------
    // difference, multiply, cast and clamp stages
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (upd) begin
            diff   <= $signed({1'b0, ref_pow}) - $signed({1'b0, pow});
            pow_s1 <= pow;
        end
        if (diff_valid) begin
            prod   <= diff * $signed({1'b0, error_coef});
            pow_s2 <= pow_s1;
        end
        if (prod_valid) begin
            step   <= step_sat;
            pow_s3 <= pow_s2;
        end
        if (step_valid) begin
            rpt.gain <= in_band ? cand[gw-1:0] : gain_reg;
            rpt.pow  <= pow_s3;
            rpt.held <= ~in_band;
        end
    end

    assign gain = gain_reg;

endmodule

/* src/lane_scaler.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module lane_scaler (
    input  logic                              clk,
    input  logic                              rst,
    input  agc_pkg::sample_block_t            din,
    input  logic                              din_valid,
    input  logic signed [`AGC_GAIN_WIDTH-1:0] gain,
    output agc_pkg::scaled_block_t            dout,
    output logic                              dout_valid
);

    // --------------------------------------------------
    // valid flag
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    // --------------------------------------------------
    // lane products
    // --------------------------------------------------
    // q1.7 times q8.8 gives q9.15 in each lane.
    always_ff @(posedge clk) begin
        if (din_valid) begin
            for (int i = 0; i < `AGC_PARALLEL; i++) begin
                dout.lane[i] <= din.lane[i] * gain;  // full width, no rounding.
            end
            dout.gain <= gain;  // gain seen in the cycle of acceptance.
        end
    end

endmodule

/* src/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t wr_data,
    input  logic     wr_valid,
    input  logic     credit,
    output payload_t rd_data,
    output logic     rd_valid
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic [cw-1:0] credits;
    logic          full;
    logic          empty;
    logic          wr_en;

    assign full     = (count == cw'(depth));
    assign empty    = (count == '0);
    assign wr_en    = wr_valid && !full;  // a write into a full queue is lost.
    assign rd_valid = !empty && (credits != '0);  // every valid cycle is a send.
    assign rd_data  = mem[rd_ptr];

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // --------------------------------------------------
    // pointers, fill level and sink credits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= cw'(depth);  // sink starts with room for a full queue.
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_valid) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_valid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({credit, rd_valid})
                2'b10: credits <= credits + 1'b1;  // returned by the sink.
                2'b01: credits <= credits - 1'b1;  // spent on a send.
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* src/agc_top.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_top (
    input  logic                       clk,
    input  logic                       rst,
    input  agc_pkg::sample_block_t     din,
    input  logic                       din_valid,
    output logic                       din_credit,
    input  logic [`AGC_POW_WIDTH-1:0]  ref_pow,
    input  logic [`AGC_COEF_WIDTH-1:0] error_coef,
    output agc_pkg::scaled_block_t     dout,
    output logic                       dout_valid,
    input  logic                       dout_credit,
    output agc_pkg::gain_report_t      rpt,
    output logic                       rpt_valid,
    input  logic                       rpt_credit
);

    logic [`AGC_POW_WIDTH-1:0]         pow;
    logic                              pow_valid;
    logic signed [`AGC_GAIN_WIDTH-1:0] gain;
    agc_pkg::gain_report_t             upd_rpt;
    logic                              upd_rpt_valid;
    agc_pkg::scaled_block_t            scaled;
    logic                              scaled_valid;

    // --------------------------------------------------
    // gain loop
    // --------------------------------------------------
    avg_power u_avg_power (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_valid (din_valid),
        .pow       (pow),
        .pow_valid (pow_valid)
    );

    gain_update u_gain_update (
        .clk        (clk),
        .rst        (rst),
        .pow        (pow),
        .pow_valid  (pow_valid),
        .ref_pow    (ref_pow),
        .error_coef (error_coef),
        .gain       (gain),
        .rpt        (upd_rpt),
        .rpt_valid  (upd_rpt_valid)
    );

    // --------------------------------------------------
    // data path and output queues
    // --------------------------------------------------
    lane_scaler u_lane_scaler (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .gain       (gain),
        .dout       (scaled),
        .dout_valid (scaled_valid)
    );

    credit_fifo #(
        .payload_t (agc_pkg::scaled_block_t),
        .depth     (`AGC_OUT_DEPTH)
    ) u_out_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (scaled),
        .wr_valid (scaled_valid),
        .credit   (dout_credit),
        .rd_data  (dout),
        .rd_valid (dout_valid)
    );

    credit_fifo #(
        .payload_t (agc_pkg::gain_report_t),
        .depth     (`AGC_RPT_DEPTH)
    ) u_rpt_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (upd_rpt),
        .wr_valid (upd_rpt_valid),
        .credit   (rpt_credit),
        .rd_data  (rpt),
        .rd_valid (rpt_valid)
    );

    // a block leaving the sample queue frees a slot for the source.
    assign din_credit = dout_valid;

endmodule

/* testbench/agc_props.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_props (
    input logic                              clk,
    input logic                              rst,
    input logic                              din_valid,
    input logic                              din_credit,
    input logic                              dout_valid,
    input logic                              dout_credit,
    input agc_pkg::gain_report_t             rpt,
    input logic                              rpt_valid,
    input logic                              rpt_credit,
    input logic                              upd_rpt_valid,
    input logic signed [`AGC_GAIN_WIDTH-1:0] gain
);

    int src_cred;  // credits held by the source.
    int out_cred;  // credits held by the sample queue.
    int rpt_cred;
    int rpt_fill;  // reports waiting in the report queue.

    always_ff @(posedge clk) begin
        if (rst) begin
            src_cred <= `AGC_OUT_DEPTH;
            out_cred <= `AGC_OUT_DEPTH;
            rpt_cred <= `AGC_RPT_DEPTH;
            rpt_fill <= 0;
        end else begin
            src_cred <= src_cred - int'(din_valid) + int'(din_credit);
            out_cred <= out_cred - int'(dout_valid) + int'(dout_credit);
            rpt_cred <= rpt_cred - int'(rpt_valid) + int'(rpt_credit);
            rpt_fill <= rpt_fill + int'(upd_rpt_valid && rpt_fill < `AGC_RPT_DEPTH)
                        - int'(rpt_valid);
        end
    end

    // --------------------------------------------------
    // credits
    // --------------------------------------------------
    a_src_credit: assert property (@(posedge clk) disable iff (rst) din_valid |-> src_cred > 0)
        else $error("source sent a block without holding a credit");
    a_out_credit: assert property (@(posedge clk) disable iff (rst) dout_valid |-> out_cred > 0)
        else $error("sample queue sent without a sink credit");
    a_rpt_credit: assert property (@(posedge clk) disable iff (rst) rpt_valid |-> rpt_cred > 0)
        else $error("report queue sent without a sink credit");

    // --------------------------------------------------
    // gain band and report loss
    // --------------------------------------------------
    a_gain_band: assert property (@(posedge clk) disable iff (rst)
        gain > `AGC_GAIN_LOW && gain < `AGC_GAIN_HIGH)
        else $error("gain register left the allowed band");
    a_rpt_band: assert property (@(posedge clk) disable iff (rst)
        rpt_valid |-> rpt.gain > `AGC_GAIN_LOW && rpt.gain < `AGC_GAIN_HIGH)
        else $error("reported gain outside the allowed band");
    a_rpt_drop: assert property (@(posedge clk) disable iff (rst)
        upd_rpt_valid |-> rpt_fill < `AGC_RPT_DEPTH)
        else $error("gain report dropped by a full report queue");

endmodule

/* testbench/agc_tb.sv */
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_tb;

    localparam int clk_period   = 8;
    localparam int total_blocks = 260;  // sum of all test lengths.
    localparam int window       = 1 << `AGC_WINDOW_LOG2;
    localparam int mean_shift   = $clog2(`AGC_PARALLEL) + `AGC_WINDOW_LOG2;
    localparam int step_shift   = 2 * `AGC_DIN_POINT + `AGC_COEF_POINT - `AGC_GAIN_POINT;

    logic                       clk = 1'b0;
    logic                       rst;
    agc_pkg::sample_block_t     din;
    logic                       din_valid;
    logic                       din_credit;
    logic [`AGC_POW_WIDTH-1:0]  ref_pow;
    logic [`AGC_COEF_WIDTH-1:0] error_coef;
    agc_pkg::scaled_block_t     dout;
    logic                       dout_valid;
    logic                       dout_credit = 1'b0;
    agc_pkg::gain_report_t      rpt;
    logic                       rpt_valid;
    logic                       rpt_credit = 1'b0;

    int                     seed = 32'h77c;
    int                     cycle;
    int                     src_credits;
    int                     slow_sink;
    int                     check_rise;
    int                     err_count;
    int                     test_err;
    int                     test_fails;
    int                     held_seen;
    int                     out_due[$];  // cycles at which sink credits go back.
    int                     rpt_due[$];
    agc_pkg::sample_block_t sent_q[$];
    agc_pkg::gain_report_t  exp_rpt_q[$];
    agc_pkg::gain_t         gain_hist[$];  // initial gain and every gain reported so far.
    int                     gain_idx;
    agc_pkg::gain_t         last_gain;
    longint                 blk_hist[window];
    longint                 win_sum;
    int                     blk_cnt;
    agc_pkg::gain_t         model_gain;

    agc_top dut (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .din_valid   (din_valid),
        .din_credit  (din_credit),
        .ref_pow     (ref_pow),
        .error_coef  (error_coef),
        .dout        (dout),
        .dout_valid  (dout_valid),
        .dout_credit (dout_credit),
        .rpt         (rpt),
        .rpt_valid   (rpt_valid),
        .rpt_credit  (rpt_credit)
    );

    bind agc_top agc_props u_props (
        .clk           (clk),
        .rst           (rst),
        .din_valid     (din_valid),
        .din_credit    (din_credit),
        .dout_valid    (dout_valid),
        .dout_credit   (dout_credit),
        .rpt           (rpt),
        .rpt_valid     (rpt_valid),
        .rpt_credit    (rpt_credit),
        .upd_rpt_valid (upd_rpt_valid),
        .gain          (gain)
    );

    always #(clk_period / 2) clk = ~clk;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic agc_pkg::gain_report_t ref_report(input longint mean, input longint g,
                                                         input longint rp, input longint coef);
        agc_pkg::gain_report_t r;
        longint                step;
        longint                cand;
        step   = ((rp - mean) * coef) >>> step_shift;
        step   = (step > 32767) ? 32767 : ((step < -32768) ? -32768 : step);  // gain format.
        cand   = g + step;
        r.pow  = agc_pkg::power_t'(mean);
        r.held = !(cand > `AGC_GAIN_LOW && cand < `AGC_GAIN_HIGH);
        r.gain = r.held ? agc_pkg::gain_t'(g) : agc_pkg::gain_t'(cand);
        return r;
    endfunction

    task automatic model_block(input longint bsum);
        agc_pkg::gain_report_t r;
        win_sum = win_sum + bsum - blk_hist[window-1];
        for (int k = window - 1; k > 0; k--) begin
            blk_hist[k] = blk_hist[k-1];
        end
        blk_hist[0] = bsum;
        blk_cnt++;
        if (blk_cnt == `AGC_UPDATE_BLOCKS) begin
            r = ref_report(win_sum >>> mean_shift, model_gain, ref_pow, error_coef);
            exp_rpt_q.push_back(r);
            model_gain = r.gain;
            blk_cnt    = 0;
        end
    endtask

    task automatic reset_model();
        src_credits = `AGC_OUT_DEPTH;
        sent_q.delete();
        exp_rpt_q.delete();
        gain_hist.delete();
        gain_hist.push_back(agc_pkg::gain_t'(`AGC_GAIN_INIT));
        gain_idx   = 0;
        last_gain  = agc_pkg::gain_t'(`AGC_GAIN_INIT);
        model_gain = agc_pkg::gain_t'(`AGC_GAIN_INIT);
        win_sum    = 0;
        blk_cnt    = 0;
        for (int k = 0; k < window; k++) begin
            blk_hist[k] = 0;
        end
    endtask

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic count_error();
        err_count++;
        test_err++;
    endtask

    task automatic check_scaled(input agc_pkg::scaled_block_t got,
                                input agc_pkg::scaled_block_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: scaled block %h, expected %h", $time, got, exp);
            count_error();
        end
    endtask

    task automatic check_report(input agc_pkg::gain_report_t got,
                                input agc_pkg::gain_report_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: gain report %h, expected %h", $time, got, exp);
            count_error();
        end
    endtask

    task automatic take_block(input agc_pkg::scaled_block_t got);
        agc_pkg::sample_block_t smp;
        agc_pkg::scaled_block_t exp;
        if (sent_q.size() == 0) begin
            $display("scaled block at %0t ns with no accepted input block left", $time);
            count_error();
        end else begin
            smp      = sent_q.pop_front();
            exp.gain = gain_hist[gain_idx];
            // the gain may only move forward through the reported gains.
            for (int j = gain_idx; j < gain_hist.size(); j++) begin
                if (gain_hist[j] == got.gain) begin
                    exp.gain = got.gain;
                    gain_idx = j;
                    break;
                end
            end
            for (int i = 0; i < `AGC_PARALLEL; i++) begin
                exp.lane[i] = agc_pkg::product_t'(longint'(smp.lane[i]) * longint'(exp.gain));
            end
            check_scaled(got, exp);
        end
    endtask

    task automatic take_report(input agc_pkg::gain_report_t got);
        agc_pkg::gain_report_t exp;
        if (exp_rpt_q.size() == 0) begin
            $display("gain report at %0t ns that the reference model did not expect", $time);
            count_error();
        end else begin
            exp = exp_rpt_q.pop_front();
            check_report(got, exp);
            gain_hist.push_back(exp.gain);  // later blocks may carry this gain.
        end
        if (got.held && got.gain != last_gain) begin
            $display("Fail at %0t ns: held report changed gain to %0d", $time, got.gain);
            count_error();
        end
        if (check_rise != 0 && got.gain <= last_gain) begin
            $display("Fail at %0t ns: gain %0d did not rise above %0d", $time, got.gain,
                     last_gain);
            count_error();
        end
        held_seen += int'(got.held);
        last_gain  = got.gain;
    endtask

    // --------------------------------------------------
    // sinks and source credits
    // --------------------------------------------------
    function automatic int sink_delay();
        return ((slow_sink != 0) ? 8 : 0) + ($random(seed) & 3);
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            if (din_credit) begin
                src_credits++;
            end
            if (dout_valid) begin
                take_block(dout);
                out_due.push_back(cycle + sink_delay());
            end
            if (rpt_valid) begin
                take_report(rpt);
                rpt_due.push_back(cycle + sink_delay());
            end
        end
    end

    always @(posedge clk) begin
        #1;
        cycle++;
        dout_credit = 1'b0;
        rpt_credit  = 1'b0;
        if (rst) begin
            out_due.delete();
            rpt_due.delete();
        end else begin
            if (out_due.size() > 0 && out_due[0] <= cycle) begin
                dout_credit = 1'b1;  // one credit per pulse.
                void'(out_due.pop_front());
            end
            if (rpt_due.size() > 0 && rpt_due[0] <= cycle) begin
                rpt_credit = 1'b1;
                void'(rpt_due.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // stimulus and tests
    // --------------------------------------------------
    task automatic send_blocks(input int n, input bit low_amp);
        agc_pkg::sample_block_t b;
        longint                 bsum;
        int                     k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            #1;
            din_valid = 1'b0;
            if (src_credits > 0 && ($random(seed) & 1) != 0) begin
                bsum = 0;
                for (int i = 0; i < `AGC_PARALLEL; i++) begin
                    if (low_amp) begin
                        b.lane[i] = (($random(seed) & 1) != 0) ? agc_pkg::sample_t'(16)
                                                                : agc_pkg::sample_t'(-16);
                    end else begin
                        b.lane[i] = agc_pkg::sample_t'($random(seed));
                    end
                    bsum += longint'(b.lane[i]) * longint'(b.lane[i]);
                end
                din       = b;
                din_valid = 1'b1;
                src_credits--;
                sent_q.push_back(b);
                model_block(bsum);
                k++;
            end
        end
        @(posedge clk);
        #1;
        din_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int n, input bit low_amp, input int rp,
                            input int coef, input int slow, input int rise, input bit want_held);
        test_err   = 0;
        held_seen  = 0;
        slow_sink  = slow;
        check_rise = rise;
        @(posedge clk);
        #1;
        ref_pow    = rp[`AGC_POW_WIDTH-1:0];
        error_coef = coef[`AGC_COEF_WIDTH-1:0];
        rst        = 1'b1;
        din_valid  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_model();
        send_blocks(n, low_amp);
        while (sent_q.size() != 0 || exp_rpt_q.size() != 0) begin
            @(negedge clk);
        end
        // every block has left the queue, so every credit is back at the source.
        if (src_credits != `AGC_OUT_DEPTH) begin
            $display("Fail at %0t ns: source holds %0d credits after the stream, expected %0d",
                     $time, src_credits, `AGC_OUT_DEPTH);
            count_error();
        end
        if (want_held && held_seen == 0) begin
            $display("no update in %s was held although the gain left the band", name);
            count_error();
        end
        test_fails += int'(test_err != 0);
        $display("%s: %0d blocks, %0d errors", name, n, test_err);
    endtask

    initial begin
        rst        = 1'b1;
        din        = '0;
        din_valid  = 1'b0;
        ref_pow    = '0;
        error_coef = '0;
        err_count  = 0;
        test_fails = 0;
        run_test("gain after reset", 12, 1'b0, 0, 0, 0, 0, 1'b0);
        run_test("random stream", 64, 1'b0, 8000, 1024, 0, 0, 1'b0);
        run_test("rising gain", 96, 1'b1, 4096, 256, 0, 1, 1'b0);
        run_test("held at band edge", 48, 1'b0, 16384, 65535, 0, 0, 1'b1);
        run_test("slow sink", 40, 1'b0, 4000, 64, 1, 0, 1'b0);
        $display("5 tests run, %0d with errors, %0d errors in total", test_fails, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(total_blocks * 40 * clk_period);
        $display("watchdog expired after %0d cycles with tests still running",
                 total_blocks * 40);
        $display("Test failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
src/agc_pkg.sv
src/avg_power.sv
src/gain_update.sv
src/lane_scaler.sv
src/credit_fifo.sv
src/agc_top.sv
testbench/agc_props.sv
testbench/agc_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the AGC testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module agc_tb --Mdir "$build" -o agc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build/agc_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
